// File: Bender.yml
package:
  name: fp_exec_cluster

sources:
  # Packages and interfaces first, then the RTL
  - common/fp_ops_pkg.sv
  - common/core_if_pkg.sv
  - common/fp_issue_if.sv
  - common/fp_result_if.sv
  - hw/fp_issue_decode.sv
  - hw/fp_noncomp_unit/fp_noncomp_unit.sv
  - hw/fp_pending_queue/fp_pending_queue.sv
  - hw/fp_exec_cluster.sv
  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/tb_fp_exec_cluster.sv

// File: common/core_if_pkg.sv
// Core side definitions for the floating-point cluster
// Instruction types as decoded by the core, register index and queue tags
package core_if_pkg;

typedef enum logic [2:0] {
   FSGNJ,
   FMIN_MAX,
   FCMP,
   FCLASS,
   FMV_X2F,
   FMV_F2X
} instr_type_e;

typedef logic [4:0] reg_idx_t;

localparam int unsigned QUEUE_DEPTH = 4;  // Pending entries, power of two
localparam int unsigned TAG_W       = $clog2(QUEUE_DEPTH);
localparam int unsigned CNT_W       = $clog2(QUEUE_DEPTH + 1);

typedef logic [TAG_W-1:0] fp_tag_t;  // Queue slot of an instruction
typedef logic [CNT_W-1:0] fp_cnt_t;  // Occupancy, 0 to QUEUE_DEPTH

endpackage

// File: common/fp_issue_if.sv
// One issued operation from the decoder to the non-computational unit
// Valid is a single-cycle strobe, there is no ready since the unit
// always accepts
`timescale 1ns/1ps

interface fp_issue_if;
import fp_ops_pkg::*;
import core_if_pkg::*;

logic     valid;
fp_tag_t  tag;   // Queue slot the result returns to
fp_op_e   op;
fp_fmt_e  fmt;
fp_sel_t  sel;
fp_word_t opa;
fp_word_t opb;

modport master (
   output valid, tag, op, fmt, sel, opa, opb
);

modport slave (
   input  valid, tag, op, fmt, sel, opa, opb
);

endinterface

// File: common/fp_ops_pkg.sv
// Floating-point encodings shared by the decoder, the non-computational
// unit and the pending queue. Formats, unit operations, function selectors,
// FCLASS bit positions, exception flags and the canonical NaNs
package fp_ops_pkg;

typedef enum logic {
   FP32,
   FP64
} fp_fmt_e;

typedef enum logic [2:0] {
   SGNJ,
   MINMAX,
   CMP,
   CLASS,
   MV_X2F,
   MV_F2X
} fp_op_e;

typedef logic [63:0] fp_word_t;   // Operand or result, FP32 lives in 31:0
typedef logic [2:0]  fp_sel_t;    // Function selector from rm
typedef logic [4:0]  fflags_t;    // NV DZ OF UF NX
typedef logic [9:0]  fp_class_t;  // One-hot FCLASS result

// Selector values per operation
localparam fp_sel_t SEL_SGNJ  = 3'd0;
localparam fp_sel_t SEL_SGNJN = 3'd1;
localparam fp_sel_t SEL_SGNJX = 3'd2;
localparam fp_sel_t SEL_MIN   = 3'd0;
localparam fp_sel_t SEL_MAX   = 3'd1;
localparam fp_sel_t SEL_LE    = 3'd0;
localparam fp_sel_t SEL_LT    = 3'd1;
localparam fp_sel_t SEL_EQ    = 3'd2;

localparam int unsigned FLAG_NV = 4;  // Invalid operation

// FCLASS bit positions
localparam int unsigned CLS_NEG_INF  = 0;
localparam int unsigned CLS_NEG_NORM = 1;
localparam int unsigned CLS_NEG_SUB  = 2;
localparam int unsigned CLS_NEG_ZERO = 3;
localparam int unsigned CLS_POS_ZERO = 4;
localparam int unsigned CLS_POS_SUB  = 5;
localparam int unsigned CLS_POS_NORM = 6;
localparam int unsigned CLS_POS_INF  = 7;
localparam int unsigned CLS_SNAN     = 8;
localparam int unsigned CLS_QNAN     = 9;

localparam logic [31:0] CANON_NAN_S = 32'h7fc00000;
localparam fp_word_t    CANON_NAN_D = 64'h7ff8000000000000;

endpackage

// File: common/fp_result_if.sv
// Tagged result from the non-computational unit back to the pending queue
// Valid is a single-cycle strobe
`timescale 1ns/1ps

interface fp_result_if;
import fp_ops_pkg::*;
import core_if_pkg::*;

logic     valid;
fp_tag_t  tag;
fp_word_t data;    // Raw result, formatting happens at write-back
fflags_t  fflags;

modport master (output valid, tag, data, fflags);
modport slave  (input  valid, tag, data, fflags);

endinterface

// File: dv/tb_clock_gen.sv
// Clock and reset source for the floating-point cluster testbench
// Free-running clock, reset held high for a fixed number of rising edges
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int CLK_PERIOD   = 10,  // ns
   parameter int RESET_CYCLES = 16
) (
   output logic clk_o,
   output logic reset_o
);

initial begin : clock_toggle
   clk_o = 1'b0;
   forever #(CLK_PERIOD / 2) clk_o = ~clk_o;
end

initial begin : reset_seq
   reset_o = 1'b1;
   repeat (RESET_CYCLES) @(posedge clk_o);
   #1 reset_o = 1'b0;  // Released together with the other inputs
end

endmodule

// File: dv/tb_fp_exec_cluster.sv
// Testbench of the floating-point execution cluster
// Random instructions from an LCG drive the DUT, a reference model predicts
// each write-back and an in-order scoreboard compares them at the falling edge
`timescale 1ns/1ps

module tb_fp_exec_cluster;
import fp_ops_pkg::*;
import core_if_pkg::*;

localparam int NUM_INSTR       = 2000;
localparam int WATCHDOG_CYCLES = NUM_INSTR * 20;
localparam int DRIVE_DELAY     = 1;  // ns after the rising edge

typedef struct packed {
   fp_word_t    data;
   fflags_t     flags;
   reg_idx_t    rd;
   logic        to_int;
   logic [31:0] cycle;   // Cycle of acceptance
} exp_t;

logic        clk, reset;
logic        flush, stall_wb, instr_valid;
instr_type_e instr_type;
fp_fmt_e     fmt;
fp_sel_t     rm;
reg_idx_t    rd;
fp_word_t    rs1, rs2;
logic        stall, fp_we, int_we;
reg_idx_t    fp_rd, int_rd;
fp_word_t    fp_result, int_result;
fflags_t     fp_fflags, int_fflags;

exp_t        exp_q[$];
logic [31:0] rng_state;
logic        exact_latency;
int          cycle_count, accept_count, wb_count, error_count;

tb_clock_gen #(.CLK_PERIOD(10), .RESET_CYCLES(16)) tb_clock_gen_inst (
   .clk_o   (clk),
   .reset_o (reset)
);

fp_exec_cluster fp_exec_cluster_inst (
   .clk_i         (clk),
   .reset_i       (reset),
   .flush_i       (flush),
   .stall_wb_i    (stall_wb),
   .instr_valid_i (instr_valid),
   .instr_type_i  (instr_type),
   .fmt_i         (fmt),
   .rm_i          (rm),
   .rd_i          (rd),
   .rs1_data_i    (rs1),
   .rs2_data_i    (rs2),
   .stall_o       (stall),
   .fp_we_o       (fp_we),
   .fp_rd_o       (fp_rd),
   .fp_result_o   (fp_result),
   .fp_fflags_o   (fp_fflags),
   .int_we_o      (int_we),
   .int_rd_o      (int_rd),
   .int_result_o  (int_result),
   .int_fflags_o  (int_fflags)
);

// ---------------------------------------------------------------------------
// Random numbers and stimulus
// ---------------------------------------------------------------------------
function automatic logic [31:0] next_rand();
   logic [15:0] hi;
   rng_state = rng_state * 32'd1664525 + 32'd1013904223;
   hi        = rng_state[31:16];
   rng_state = rng_state * 32'd1664525 + 32'd1013904223;
   return {hi, rng_state[31:16]};  // Upper halves only
endfunction

// Special values in the active format, otherwise a random word
function automatic fp_word_t pick_operand(input logic dbl);
   logic [31:0] r0, r1, r2;
   fp_word_t    w;
   r0 = next_rand();
   r1 = next_rand();
   r2 = next_rand();
   w  = {r1, r2};
   if (r0[3:0] < 4'd10) begin
      if (dbl) begin
         case (r0[6:4])
            3'd0:    w[62:0] = '0;
            3'd1:    w[62:0] = {11'h7ff, 52'd0};
            3'd2:    w[62:0] = {11'h7ff, 1'b1, r2, r1[18:0]};        // Quiet NaN
            3'd3:    w[62:0] = {11'h7ff, 1'b0, r2, r1[18:1], 1'b1};  // Signaling NaN
            3'd4:    w[62:0] = {11'h000, r2, r1[19:1], 1'b1};        // Subnormal
            default: w[62:0] = w[62:0];
         endcase
         w[63] = r0[8];
      end else begin
         case (r0[6:4])
            3'd0:    w[30:0] = '0;
            3'd1:    w[30:0] = {8'hff, 23'd0};
            3'd2:    w[30:0] = {8'hff, 1'b1, r2[21:0]};
            3'd3:    w[30:0] = {8'hff, 1'b0, r2[20:0], 1'b1};
            3'd4:    w[30:0] = {8'h00, r2[21:0], 1'b1};
            default: w[30:0] = w[30:0];
         endcase
         w[31] = r0[8];
      end
   end
   return w;
endfunction

task automatic drive_instr(input logic valid);
   logic [31:0] r;
   r           = next_rand();
   instr_valid = valid;
   instr_type  = instr_type_e'(3'(r[7:0] % 8'd6));
   fmt         = fp_fmt_e'(r[8]);
   rd          = r[13:9];
   case (instr_type)
      FSGNJ, FCMP: rm = 3'(r[23:16] % 8'd3);
      FMIN_MAX:    rm = {2'b00, r[16]};
      default:     rm = r[26:24];  // Ignored by the unit
   endcase
   rs1 = pick_operand(r[8]);
   rs2 = (r[30:28] == 3'd0) ? rs1 : pick_operand(r[8]);  // Equal operands now and then
endtask

task automatic next_cycle();
   @(posedge clk);
   #(DRIVE_DELAY);
endtask

task automatic drain();
   instr_valid = 1'b0;
   stall_wb    = 1'b0;
   flush       = 1'b0;
   while (exp_q.size() != 0) next_cycle();
   repeat (4) next_cycle();
endtask

// ---------------------------------------------------------------------------
// Reference model
// ---------------------------------------------------------------------------
function automatic logic [9:0] class_of(input fp_word_t w, input logic dbl);
   logic        s;
   logic        e_max;
   logic        e_zero;
   logic [51:0] m;
   logic [9:0]  c;
   s      = dbl ? w[63] : w[31];
   e_max  = dbl ? (w[62:52] == 11'h7ff) : (w[30:23] == 8'hff);
   e_zero = dbl ? (w[62:52] == 11'h000) : (w[30:23] == 8'h00);
   m      = dbl ? w[51:0] : {w[22:0], 29'd0};  // Quiet bit lands in 51
   if (e_max && m == '0) c = s ? 10'h001 : 10'h080;
   else if (e_max) c = m[51] ? 10'h200 : 10'h100;
   else if (e_zero && m == '0) c = s ? 10'h008 : 10'h010;
   else if (e_zero) c = s ? 10'h004 : 10'h020;
   else c = s ? 10'h002 : 10'h040;
   return c;
endfunction

// Signed integer with the same order as the value, both zeros map to 0
function automatic logic signed [64:0] order_key(input fp_word_t w, input logic dbl);
   logic [62:0] mag;
   mag = dbl ? w[62:0] : {32'd0, w[30:0]};
   if (dbl ? w[63] : w[31]) return -$signed({2'b00, mag});
   else return $signed({2'b00, mag});
endfunction

function automatic exp_t expected_result(input instr_type_e itype, input logic dbl,
                                         input fp_sel_t sel, input fp_word_t a,
                                         input fp_word_t b);
   exp_t               e;
   logic [9:0]         ca, cb;
   logic               nan_a, nan_b, snan;
   logic signed [64:0] ka, kb;
   logic               sa, sb, sn, take_a;
   fp_word_t           raw;
   ca    = class_of(a, dbl);
   cb    = class_of(b, dbl);
   nan_a = ca[8] | ca[9];
   nan_b = cb[8] | cb[9];
   snan  = ca[8] | cb[8];
   ka    = order_key(a, dbl);
   kb    = order_key(b, dbl);
   sa    = dbl ? a[63] : a[31];
   sb    = dbl ? b[63] : b[31];
   e     = '0;
   raw   = a;
   case (itype)
      FSGNJ: begin
         sn  = (sel == 3'd0) ? sb : ((sel == 3'd1) ? ~sb : sa ^ sb);
         raw = dbl ? {sn, a[62:0]} : {a[63:32], sn, a[30:0]};
      end
      FMIN_MAX: begin
         e.flags[FLAG_NV] = snan;
         if (nan_a && nan_b) raw = dbl ? CANON_NAN_D : {32'd0, CANON_NAN_S};
         else if (nan_a) raw = b;
         else if (nan_b) raw = a;
         else begin
            if (ka == kb) take_a = (sel == 3'd0) ? sa : ~sa;  // -0 below +0
            else take_a = (sel == 3'd0) ? (ka < kb) : (ka > kb);
            raw = take_a ? a : b;
         end
      end
      FCMP: begin
         raw = '0;
         if (sel == 3'd2) begin
            raw[0]           = !nan_a && !nan_b && (ka == kb);
            e.flags[FLAG_NV] = snan;
         end else begin
            raw[0]           = !nan_a && !nan_b && ((sel == 3'd1) ? (ka < kb) : (ka <= kb));
            e.flags[FLAG_NV] = nan_a | nan_b;
         end
      end
      FCLASS:  raw = {54'd0, ca};
      default: raw = a;  // Both moves
   endcase
   e.to_int = (itype == FCMP) || (itype == FCLASS) || (itype == FMV_F2X);
   if (!dbl) raw = e.to_int ? {{32{raw[31]}}, raw[31:0]} : {32'hffff_ffff, raw[31:0]};
   e.data = raw;
   return e;
endfunction

// ---------------------------------------------------------------------------
// Error reporting and scoreboard
// ---------------------------------------------------------------------------
task automatic report_mismatch(input string name, input fp_word_t exp_v, input fp_word_t got_v);
   $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp_v, got_v);
   error_count++;
endtask

task automatic report_problem(input string msg);
   $display("ERROR at %0t ns: %s", $time, msg);
   error_count++;
endtask

task automatic check_writeback(input exp_t e);
   if (int_we !== e.to_int) report_mismatch("int_we_o", e.to_int, int_we);
   if (int_we) begin
      if (int_rd !== e.rd) report_mismatch("int_rd_o", e.rd, int_rd);
      if (int_result !== e.data) report_mismatch("int_result_o", e.data, int_result);
      if (int_fflags !== e.flags) report_mismatch("int_fflags_o", e.flags, int_fflags);
   end else begin
      if (fp_rd !== e.rd) report_mismatch("fp_rd_o", e.rd, fp_rd);
      if (fp_result !== e.data) report_mismatch("fp_result_o", e.data, fp_result);
      if (fp_fflags !== e.flags) report_mismatch("fp_fflags_o", e.flags, fp_fflags);
   end
   if (exact_latency && (cycle_count - int'(e.cycle) != 3))
      report_problem("write-back after an idle accept did not come 3 cycles later");
   else if (cycle_count - int'(e.cycle) < 3)
      report_problem("write-back came less than 3 cycles after acceptance");
   wb_count++;
endtask

// Falling edge, all DUT outputs and driven inputs are settled here
always @(negedge clk) begin : scoreboard
   exp_t e;
   logic room;
   logic exp_stall;
   if (reset) begin
      exp_q.delete();
   end else begin
      cycle_count++;
      room      = (exp_q.size() < QUEUE_DEPTH);
      exp_stall = (exp_q.size() == QUEUE_DEPTH);
      if (stall !== exp_stall) report_mismatch("stall_o", exp_stall, stall);
      if (stall_wb && (fp_we || int_we))
         report_problem("write-enable high while stall_wb_i is high");
      if (fp_we === 1'b1 && int_we === 1'b1) begin
         report_problem("both write-enables high in one cycle");
      end else if (fp_we === 1'b1 || int_we === 1'b1) begin
         if (exp_q.size() == 0) report_problem("write-back with no pending instruction");
         else check_writeback(exp_q.pop_front());
      end
      if (flush) begin
         exp_q.delete();  // Accept in the flush cycle is dropped too
      end else if (instr_valid && room) begin
         e       = expected_result(instr_type, fmt == FP64, rm, rs1, rs2);
         e.rd    = rd;
         e.cycle = cycle_count;
         exp_q.push_back(e);
         accept_count++;
      end
   end
end

initial begin : watchdog
   repeat (WATCHDOG_CYCLES) @(posedge clk);
   $display("Watchdog expired, the run did not finish in %0d cycles", WATCHDOG_CYCLES);
   $display("Verification failed");
   $finish;
end

// ---------------------------------------------------------------------------
// Test sequence
// ---------------------------------------------------------------------------
initial begin : stimulus
   logic [31:0] r;
   rng_state     = 32'hd72dccec;
   exact_latency = 1'b0;
   cycle_count   = 0;
   accept_count  = 0;
   wb_count      = 0;
   error_count   = 0;
   flush         = 1'b0;
   stall_wb      = 1'b0;
   instr_valid   = 1'b0;
   instr_type    = FSGNJ;
   fmt           = FP32;
   rm            = '0;
   rd            = '0;
   rs1           = '0;
   rs2           = '0;
   @(negedge reset);

   // Single instructions into an empty queue
   exact_latency = 1'b1;
   repeat (8) begin
      drive_instr(1'b1);
      next_cycle();
      instr_valid = 1'b0;
      while (exp_q.size() != 0) next_cycle();
      next_cycle();
   end
   exact_latency = 1'b0;

   // Fill the queue behind a blocked write-back port
   stall_wb = 1'b1;
   repeat (8) begin
      drive_instr(1'b1);
      next_cycle();
   end
   drain();

   while (accept_count < NUM_INSTR) begin
      r = next_rand();
      drive_instr(r[3:0] < 4'd11);
      stall_wb = (r[25:16] < 10'd205);  // About one cycle in five
      next_cycle();
   end
   drain();

   // Flush with pending entries, then nothing old may retire
   stall_wb = 1'b1;
   repeat (3) begin
      drive_instr(1'b1);
      next_cycle();
   end
   drive_instr(1'b1);
   flush = 1'b1;
   next_cycle();
   flush       = 1'b0;
   instr_valid = 1'b0;
   stall_wb    = 1'b0;
   repeat (6) next_cycle();
   repeat (12) begin
      r = next_rand();
      drive_instr(r[0] | r[1]);
      stall_wb = (r[25:16] < 10'd205);
      next_cycle();
   end
   drain();

   $display("Accepted %0d instructions, checked %0d write-backs, %0d errors",
            accept_count, wb_count, error_count);
   if (error_count == 0) begin
      $display("Verification passed");
   end else begin
      $display("Verification failed");
   end
   $finish;
end

endmodule

// File: hw/fp_exec_cluster.sv
// Top level of the floating-point execution cluster
// Decoder and non-computational unit form the execute path, the pending
// queue tags each accepted instruction and writes back in order
`timescale 1ns/1ps

module fp_exec_cluster (
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  flush_i,
   input  logic                  stall_wb_i,
   input  logic                  instr_valid_i,
   input  core_if_pkg::instr_type_e instr_type_i,
   input  fp_ops_pkg::fp_fmt_e   fmt_i,
   input  fp_ops_pkg::fp_sel_t   rm_i,
   input  core_if_pkg::reg_idx_t rd_i,
   input  fp_ops_pkg::fp_word_t  rs1_data_i,
   input  fp_ops_pkg::fp_word_t  rs2_data_i,
   output logic                  stall_o,
   // Floating-point register file
   output logic                  fp_we_o,
   output core_if_pkg::reg_idx_t fp_rd_o,
   output fp_ops_pkg::fp_word_t  fp_result_o,
   output fp_ops_pkg::fflags_t   fp_fflags_o,
   // Integer register file
   output logic                  int_we_o,
   output core_if_pkg::reg_idx_t int_rd_o,
   output fp_ops_pkg::fp_word_t  int_result_o,
   output fp_ops_pkg::fflags_t   int_fflags_o
);
import core_if_pkg::*;

logic    accept;    // Offered and the queue has room
logic    to_int;
fp_tag_t alloc_tag;

fp_issue_if  issue_if_inst ();
fp_result_if result_if_inst ();

fp_issue_decode fp_issue_decode_inst (
   .instr_valid_i (instr_valid_i),
   .accept_i      (accept),
   .instr_type_i  (instr_type_i),
   .fmt_i         (fmt_i),
   .rm_i          (rm_i),
   .rs1_data_i    (rs1_data_i),
   .rs2_data_i    (rs2_data_i),
   .tag_i         (alloc_tag),
   .issue_o       (issue_if_inst.master),
   .to_int_o      (to_int)
);

fp_noncomp_unit fp_noncomp_unit_inst (
   .clk_i    (clk_i),
   .reset_i  (reset_i),
   .flush_i  (flush_i),
   .issue_i  (issue_if_inst.slave),
   .result_o (result_if_inst.master)
);

fp_pending_queue fp_pending_queue_inst (
   .clk_i        (clk_i),
   .reset_i      (reset_i),
   .flush_i      (flush_i),
   .stall_wb_i   (stall_wb_i),
   .alloc_i      (instr_valid_i),
   .to_int_i     (to_int),
   .fmt_i        (fmt_i),
   .rd_i         (rd_i),
   .result_i     (result_if_inst.slave),
   .accept_o     (accept),
   .tag_o        (alloc_tag),
   .stall_o      (stall_o),
   .fp_we_o      (fp_we_o),
   .fp_rd_o      (fp_rd_o),
   .fp_result_o  (fp_result_o),
   .fp_fflags_o  (fp_fflags_o),
   .int_we_o     (int_we_o),
   .int_rd_o     (int_rd_o),
   .int_result_o (int_result_o),
   .int_fflags_o (int_fflags_o)
);

endmodule

// File: hw/fp_issue_decode.sv
// Issue decoder of the floating-point cluster, purely combinational
// Maps the core instruction type to a unit operation, forwards rm as the
// function selector and picks the destination register file
`timescale 1ns/1ps

module fp_issue_decode (
   input  logic                     instr_valid_i,
   input  logic                     accept_i,      // From the pending queue
   input  core_if_pkg::instr_type_e instr_type_i,
   input  fp_ops_pkg::fp_fmt_e      fmt_i,
   input  fp_ops_pkg::fp_sel_t      rm_i,
   input  fp_ops_pkg::fp_word_t     rs1_data_i,
   input  fp_ops_pkg::fp_word_t     rs2_data_i,
   input  core_if_pkg::fp_tag_t     tag_i,
   fp_issue_if.master               issue_o,
   output logic                     to_int_o       // Result goes to the integer file
);
import fp_ops_pkg::*;
import core_if_pkg::*;

always_comb begin : op_decode
   case (instr_type_i)
      FSGNJ:    issue_o.op = SGNJ;
      FMIN_MAX: issue_o.op = MINMAX;
      FCMP:     issue_o.op = CMP;
      FCLASS:   issue_o.op = CLASS;
      FMV_X2F:  issue_o.op = MV_X2F;
      FMV_F2X:  issue_o.op = MV_F2X;
      default:  issue_o.op = SGNJ;  // Unused encodings
   endcase
end

// Compare, classify and the move to X write an integer register
assign to_int_o = (issue_o.op == CMP) || (issue_o.op == CLASS) || (issue_o.op == MV_F2X);

assign issue_o.valid = instr_valid_i & accept_i;
assign issue_o.tag   = tag_i;
assign issue_o.fmt   = fmt_i;
assign issue_o.sel   = rm_i;
assign issue_o.opa   = rs1_data_i;  // Integer source for MV_X2F
assign issue_o.opb   = rs2_data_i;

endmodule

// File: hw/fp_noncomp_unit/fp_noncomp_unit.sv
// Non-computational floating-point unit, fixed latency of two cycles
// Stage 1 classifies both operands, stage 2 forms result and flags
// A flush drops everything in flight
`timescale 1ns/1ps

module fp_noncomp_unit (
   input  logic        clk_i,
   input  logic        reset_i,
   input  logic        flush_i,
   fp_issue_if.slave   issue_i,
   fp_result_if.master result_o
);
import fp_ops_pkg::*;
import core_if_pkg::*;

// One-hot class of an operand in the selected format
function automatic fp_class_t fp_classify(input fp_word_t w, input fp_fmt_e fmt);
   logic      sign;
   logic      exp_ones;
   logic      exp_zero;
   logic      man_zero;
   logic      quiet;
   fp_class_t cls;
   cls = '0;
   if (fmt == FP64) begin
      sign     = w[63];
      exp_ones = &w[62:52];
      exp_zero = ~|w[62:52];
      man_zero = ~|w[51:0];
      quiet    = w[51];
   end else begin
      sign     = w[31];
      exp_ones = &w[30:23];
      exp_zero = ~|w[30:23];
      man_zero = ~|w[22:0];
      quiet    = w[22];
   end
   if (exp_ones && man_zero) cls[sign ? CLS_NEG_INF : CLS_POS_INF] = 1'b1;
   else if (exp_ones) cls[quiet ? CLS_QNAN : CLS_SNAN] = 1'b1;
   else if (exp_zero && man_zero) cls[sign ? CLS_NEG_ZERO : CLS_POS_ZERO] = 1'b1;
   else if (exp_zero) cls[sign ? CLS_NEG_SUB : CLS_POS_SUB] = 1'b1;
   else cls[sign ? CLS_NEG_NORM : CLS_POS_NORM] = 1'b1;
   return cls;
endfunction

logic      s1_valid_q, s2_valid_q;
fp_tag_t   s1_tag_q, s2_tag_q;
fp_op_e    s1_op_q;
fp_fmt_e   s1_fmt_q;
fp_sel_t   s1_sel_q;
fp_word_t  s1_opa_q, s1_opb_q;
fp_class_t s1_cls_a_q, s1_cls_b_q;
fp_word_t  s2_data_q;
fflags_t   s2_flags_q;

logic        sign_a, sign_b, sign_inj;
logic [62:0] mag_a, mag_b;
logic        nan_a, nan_b, nan_any, snan_any, zeros;
logic        a_eq, a_lt, pick_a_min, pick_a_max;
fp_word_t    canon_nan, res_data;
fflags_t     res_flags;

// --------------------------------------------------------------------------
// Pipeline registers
// --------------------------------------------------------------------------
always_ff @(posedge clk_i) begin : pipe_ctrl
   if (reset_i || flush_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
   end else begin
      s1_valid_q <= issue_i.valid;
      s2_valid_q <= s1_valid_q;
   end
end

always_ff @(posedge clk_i) begin : pipe_data
   if (issue_i.valid) begin
      s1_tag_q   <= issue_i.tag;
      s1_op_q    <= issue_i.op;
      s1_fmt_q   <= issue_i.fmt;
      s1_sel_q   <= issue_i.sel;
      s1_opa_q   <= issue_i.opa;
      s1_opb_q   <= issue_i.opb;
      s1_cls_a_q <= fp_classify(issue_i.opa, issue_i.fmt);
      s1_cls_b_q <= fp_classify(issue_i.opb, issue_i.fmt);
   end
   if (s1_valid_q) begin
      s2_tag_q   <= s1_tag_q;
      s2_data_q  <= res_data;
      s2_flags_q <= res_flags;
   end
end

// --------------------------------------------------------------------------
// Stage 2 result logic
// --------------------------------------------------------------------------
always_comb begin : fmt_fields
   if (s1_fmt_q == FP64) begin
      sign_a    = s1_opa_q[63];
      sign_b    = s1_opb_q[63];
      mag_a     = s1_opa_q[62:0];
      mag_b     = s1_opb_q[62:0];
      canon_nan = CANON_NAN_D;
   end else begin
      sign_a    = s1_opa_q[31];
      sign_b    = s1_opb_q[31];
      mag_a     = {32'd0, s1_opa_q[30:0]};
      mag_b     = {32'd0, s1_opb_q[30:0]};
      canon_nan = {32'd0, CANON_NAN_S};  // Boxed by the queue
   end
end

assign nan_a    = s1_cls_a_q[CLS_SNAN] | s1_cls_a_q[CLS_QNAN];
assign nan_b    = s1_cls_b_q[CLS_SNAN] | s1_cls_b_q[CLS_QNAN];
assign nan_any  = nan_a | nan_b;
assign snan_any = s1_cls_a_q[CLS_SNAN] | s1_cls_b_q[CLS_SNAN];
assign zeros    = (s1_cls_a_q[CLS_NEG_ZERO] | s1_cls_a_q[CLS_POS_ZERO]) &
                  (s1_cls_b_q[CLS_NEG_ZERO] | s1_cls_b_q[CLS_POS_ZERO]);

// Ordering of non-NaN values, +0 and -0 compare equal
assign a_eq = zeros || ((sign_a == sign_b) && (mag_a == mag_b));
assign a_lt = !zeros && ((sign_a != sign_b) ? sign_a :
                         (sign_a ? (mag_a > mag_b) : (mag_a < mag_b)));

// -0 is the smaller zero for min and max
assign pick_a_min = a_lt || (zeros && sign_a);
assign pick_a_max = (!a_lt && !a_eq) || (zeros && !sign_a);

always_comb begin : result_select
   res_data  = s1_opa_q;
   res_flags = '0;
   sign_inj  = sign_b;
   case (s1_op_q)
      SGNJ: begin
         case (s1_sel_q)
            SEL_SGNJ:  sign_inj = sign_b;
            SEL_SGNJN: sign_inj = ~sign_b;
            SEL_SGNJX: sign_inj = sign_a ^ sign_b;
            default:   sign_inj = sign_b;
         endcase
         if (s1_fmt_q == FP64) res_data = {sign_inj, s1_opa_q[62:0]};
         else res_data = {s1_opa_q[63:32], sign_inj, s1_opa_q[30:0]};
      end
      MINMAX: begin
         res_flags[FLAG_NV] = snan_any;  // Signaling NaN input only
         if (nan_a && nan_b) res_data = canon_nan;
         else if (nan_a) res_data = s1_opb_q;
         else if (nan_b) res_data = s1_opa_q;
         else begin
            case (s1_sel_q)
               SEL_MIN: res_data = pick_a_min ? s1_opa_q : s1_opb_q;
               SEL_MAX: res_data = pick_a_max ? s1_opa_q : s1_opb_q;
               default: res_data = canon_nan;
            endcase
         end
      end
      CMP: begin
         res_data = '0;
         case (s1_sel_q)
            SEL_EQ: begin
               res_data[0]        = !nan_any && a_eq;
               res_flags[FLAG_NV] = snan_any;  // Quiet compare
            end
            SEL_LT: begin
               res_data[0]        = !nan_any && a_lt;
               res_flags[FLAG_NV] = nan_any;
            end
            SEL_LE: begin
               res_data[0]        = !nan_any && (a_lt || a_eq);
               res_flags[FLAG_NV] = nan_any;
            end
            default: res_data = '0;
         endcase
      end
      CLASS:   res_data = {54'd0, s1_cls_a_q};
      default: res_data = s1_opa_q;  // Moves carry raw bits
   endcase
end

assign result_o.valid  = s2_valid_q;
assign result_o.tag    = s2_tag_q;
assign result_o.data   = s2_data_q;
assign result_o.fflags = s2_flags_q;

// Every issued operation comes back exactly two cycles later
a_fixed_latency: assert property (@(posedge clk_i) disable iff (reset_i)
   issue_i.valid && !flush_i ##1 !flush_i |=> result_o.valid);

endmodule

// File: hw/fp_pending_queue/fp_pending_queue.sv
// Pending-operations queue of the floating-point cluster
// Hands out the tail slot as tag, collects results by tag and retires
// in order, one entry per cycle, with NaN-boxing or sign extension
`timescale 1ns/1ps

module fp_pending_queue (
   input  logic                 clk_i,
   input  logic                 reset_i,
   input  logic                 flush_i,
   input  logic                 stall_wb_i,
   input  logic                 alloc_i,     // Instruction offered
   input  logic                 to_int_i,
   input  fp_ops_pkg::fp_fmt_e  fmt_i,
   input  core_if_pkg::reg_idx_t rd_i,
   fp_result_if.slave           result_i,
   output logic                 accept_o,
   output core_if_pkg::fp_tag_t tag_o,
   output logic                 stall_o,
   output logic                 fp_we_o,
   output core_if_pkg::reg_idx_t fp_rd_o,
   output fp_ops_pkg::fp_word_t fp_result_o,
   output fp_ops_pkg::fflags_t  fp_fflags_o,
   output logic                 int_we_o,
   output core_if_pkg::reg_idx_t int_rd_o,
   output fp_ops_pkg::fp_word_t int_result_o,
   output fp_ops_pkg::fflags_t  int_fflags_o
);
import fp_ops_pkg::*;
import core_if_pkg::*;

fp_tag_t  head_q, tail_q;
fp_cnt_t  count_q;
logic [QUEUE_DEPTH-1:0] done_q;
logic     retire;
fp_tag_t  result_rel;  // Distance of a returning tag from the head

// Entry payload
reg_idx_t rd_q     [QUEUE_DEPTH];
logic     to_int_q [QUEUE_DEPTH];
fp_fmt_e  fmt_q    [QUEUE_DEPTH];
fp_word_t data_q   [QUEUE_DEPTH];
fflags_t  flags_q  [QUEUE_DEPTH];

fp_word_t head_data;
logic     head_s;     // Head entry is single precision

assign stall_o  = (count_q == fp_cnt_t'(QUEUE_DEPTH));
assign accept_o = alloc_i & ~stall_o;
assign tag_o    = tail_q;
assign retire   = done_q[head_q] & ~stall_wb_i;

// --------------------------------------------------------------------------
// Pointers, occupancy and done bits
// --------------------------------------------------------------------------
always_ff @(posedge clk_i) begin : queue_ctrl
   if (reset_i || flush_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      done_q  <= '0;
   end else begin
      if (accept_o) tail_q <= tail_q + 1'b1;  // Wraps, depth is a power of two
      if (retire) head_q <= head_q + 1'b1;
      case ({accept_o, retire})
         2'b10:   count_q <= count_q + 1'b1;
         2'b01:   count_q <= count_q - 1'b1;
         default: count_q <= count_q;
      endcase
      if (accept_o) done_q[tail_q] <= 1'b0;
      if (result_i.valid) done_q[result_i.tag] <= 1'b1;
      if (retire) done_q[head_q] <= 1'b0;
   end
end

always_ff @(posedge clk_i) begin : queue_data
   if (accept_o) begin
      rd_q[tail_q]     <= rd_i;
      to_int_q[tail_q] <= to_int_i;
      fmt_q[tail_q]    <= fmt_i;
   end
   if (result_i.valid) begin
      data_q[result_i.tag]  <= result_i.data;
      flags_q[result_i.tag] <= result_i.fflags;
   end
end

// --------------------------------------------------------------------------
// Write-back
// --------------------------------------------------------------------------
assign head_data = data_q[head_q];
assign head_s    = (fmt_q[head_q] == FP32);

assign fp_we_o     = retire & ~to_int_q[head_q];
assign fp_rd_o     = rd_q[head_q];
assign fp_result_o = head_s ? {32'hffff_ffff, head_data[31:0]} : head_data;  // NaN-box
assign fp_fflags_o = flags_q[head_q];

// Compare and class results have bit 31 clear, so only moves really extend
assign int_we_o     = retire & to_int_q[head_q];
assign int_rd_o     = rd_q[head_q];
assign int_result_o = head_s ? {{32{head_data[31]}}, head_data[31:0]} : head_data;
assign int_fflags_o = flags_q[head_q];

assign result_rel = result_i.tag - head_q;

// A result belongs to an allocated entry that is still waiting
a_result_pending: assert property (@(posedge clk_i) disable iff (reset_i)
   result_i.valid |-> (fp_cnt_t'(result_rel) < count_q) && !done_q[result_i.tag]);

a_count_bound: assert property (@(posedge clk_i) disable iff (reset_i)
   count_q <= fp_cnt_t'(QUEUE_DEPTH));

endmodule

// File: list.f
common/fp_ops_pkg.sv
common/core_if_pkg.sv
common/fp_issue_if.sv
common/fp_result_if.sv
hw/fp_issue_decode.sv
hw/fp_noncomp_unit/fp_noncomp_unit.sv
hw/fp_pending_queue/fp_pending_queue.sv
hw/fp_exec_cluster.sv
dv/tb_clock_gen.sv
dv/tb_fp_exec_cluster.sv
